//--- design/wb_bus_pkg.sv
package wb_bus_pkg;

  // ########################################
  // bus control states
  // ########################################

  // arbiter transaction state.
  typedef enum logic {
    ARB_IDLE = 1'b0, // waiting for cyc and stb.
    ARB_WAIT = 1'b1  // strobe issued, waiting for ack or timeout.
  } arb_state_e;

  // register bank ack delay state.
  typedef enum logic {
    BANK_IDLE  = 1'b0,
    BANK_DELAY = 1'b1 // counting down wait cycles.
  } bank_state_e;

endpackage

//--- design/wb_bus_watchdog.sv
`include "wb_fabric_consts.svh"

module wb_bus_watchdog #(
  parameter int TIMEOUT = `WB_TIMEOUT
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic count_en_i,
  output logic timeout_o
);

  localparam int CNT_W = $clog2(TIMEOUT + 1);

  logic [CNT_W-1:0] wait_cnt;

  // saturating wait counter, cleared whenever the bus is not waiting.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !count_en_i) begin
      wait_cnt  <= '0;
      timeout_o <= 1'b0;
    end else begin
      if (wait_cnt != CNT_W'(TIMEOUT)) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      timeout_o <= (wait_cnt == CNT_W'(TIMEOUT)); // full count reached.
    end
  end

  // ########################################
  // checks
  // ########################################

  // a dropped enable must have cleared the flag by the next cycle.
  a_no_stale_timeout: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !$past(count_en_i) |-> !timeout_o
  );

endmodule

//--- design/wb_fabric_consts.svh
`ifndef WB_FABRIC_CONSTS_SVH
`define WB_FABRIC_CONSTS_SVH

// bus widths.
`define WB_ADR_W      32
`define WB_DAT_W      16
`define WB_SEL_W      2
`define WB_NUM_SLAVES 2

// address map, upper 16 bits compared against base and high.
`define SLV0_BASE 32'h0001_0000
`define SLV0_HIGH 16'h0001
`define SLV1_BASE 32'h0002_0000
`define SLV1_HIGH 16'h0003

// slave 1 ack delay, in cycles.
`define SLV1_WAIT 3

// wait cycles before a bus error.
`define WB_TIMEOUT 16

`endif

//--- design/wb_fabric_top.sv
`include "wb_fabric_consts.svh"

module wb_fabric_top
  import wb_map_pkg::*;
(
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wbm_cyc_i,
  input  logic                 wbm_stb_i,
  input  logic                 wbm_we_i,
  input  logic [`WB_SEL_W-1:0] wbm_sel_i,
  input  logic [`WB_ADR_W-1:0] wbm_adr_i,
  input  logic [`WB_DAT_W-1:0] wbm_dat_i,
  output logic [`WB_DAT_W-1:0] wbm_dat_o,
  output logic                 wbm_ack_o,
  output logic                 wbm_err_o
);

  // decoder results.
  slave_hit_t           hit;
  slave_id_e            slave_id;
  logic                 no_hit;
  logic [`WB_ADR_W-1:0] offset_adr;

  // watchdog.
  logic count_en;
  logic timeout;

  // slave bus.
  slave_hit_t           wbs_cyc;
  slave_hit_t           wbs_stb;
  slave_hit_t           wbs_ack;
  logic                 wbs_we;
  logic [`WB_SEL_W-1:0] wbs_sel;
  logic [`WB_ADR_W-1:0] wbs_adr;
  logic [`WB_DAT_W-1:0] wbs_dat;
  logic [`WB_DAT_W-1:0] wbs0_dat;
  logic [`WB_DAT_W-1:0] wbs1_dat;

  // ########################################
  // decode and timeout, side by side
  // ########################################

  wbs_addr_decode u_addr_decode (
    .wbm_adr_i    (wbm_adr_i),
    .hit_o        (hit),
    .slave_id_o   (slave_id),
    .no_hit_o     (no_hit),
    .offset_adr_o (offset_adr)
  );

  wb_bus_watchdog #(.TIMEOUT(`WB_TIMEOUT)) u_watchdog (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .count_en_i (count_en),
    .timeout_o  (timeout)
  );

  wbs_arbiter u_arbiter (
    .wb_clk_i     (wb_clk_i),     .wb_rst_i     (wb_rst_i),
    .wbm_cyc_i    (wbm_cyc_i),    .wbm_stb_i    (wbm_stb_i),
    .wbm_we_i     (wbm_we_i),     .wbm_sel_i    (wbm_sel_i),
    .wbm_dat_i    (wbm_dat_i),    .wbm_dat_o    (wbm_dat_o),
    .wbm_ack_o    (wbm_ack_o),    .wbm_err_o    (wbm_err_o),
    .hit_i        (hit),          .slave_id_i   (slave_id),
    .no_hit_i     (no_hit),       .offset_adr_i (offset_adr),
    .timeout_i    (timeout),      .count_en_o   (count_en),
    .wbs_cyc_o    (wbs_cyc),      .wbs_stb_o    (wbs_stb),
    .wbs_we_o     (wbs_we),       .wbs_sel_o    (wbs_sel),
    .wbs_adr_o    (wbs_adr),      .wbs_dat_o    (wbs_dat),
    .wbs_ack_i    (wbs_ack),      .wbs0_dat_i   (wbs0_dat),
    .wbs1_dat_i   (wbs1_dat)
  );

  // ########################################
  // bus targets
  // ########################################

  wbs_reg_bank #(.WAIT_CYCLES(0)) u_bank_fast (
    .wb_clk_i  (wb_clk_i),   .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc[0]), .wbs_stb_i (wbs_stb[0]),
    .wbs_we_i  (wbs_we),     .wbs_sel_i (wbs_sel),
    .wbs_adr_i (wbs_adr),    .wbs_dat_i (wbs_dat),
    .wbs_dat_o (wbs0_dat),   .wbs_ack_o (wbs_ack[0])
  );

  wbs_reg_bank #(.WAIT_CYCLES(`SLV1_WAIT)) u_bank_slow (
    .wb_clk_i  (wb_clk_i),   .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc[1]), .wbs_stb_i (wbs_stb[1]),
    .wbs_we_i  (wbs_we),     .wbs_sel_i (wbs_sel),
    .wbs_adr_i (wbs_adr),    .wbs_dat_i (wbs_dat),
    .wbs_dat_o (wbs1_dat),   .wbs_ack_o (wbs_ack[1])
  );

endmodule

//--- design/wb_map_pkg.sv
`include "wb_fabric_consts.svh"

package wb_map_pkg;

  // ########################################
  // address map types
  // ########################################

  // encoded slave index.
  typedef enum logic {
    SLV_FAST = 1'b0, // register bank, no wait states.
    SLV_SLOW = 1'b1  // register bank with fixed wait.
  } slave_id_e;

  // one bit per slave window.
  typedef logic [`WB_NUM_SLAVES-1:0] slave_hit_t;

endpackage

//--- design/wbs_addr_decode.sv
`include "wb_fabric_consts.svh"

module wbs_addr_decode
  import wb_map_pkg::*;
(
  input  logic [`WB_ADR_W-1:0] wbm_adr_i,
  output slave_hit_t           hit_o,
  output slave_id_e            slave_id_o,
  output logic                 no_hit_o,
  output logic [`WB_ADR_W-1:0] offset_adr_o
);

  // window table, index is the slave number.
  localparam logic [`WB_ADR_W-1:0] SLV_BASE [`WB_NUM_SLAVES] = '{`SLV0_BASE, `SLV1_BASE};
  localparam logic [15:0]          SLV_HIGH [`WB_NUM_SLAVES] = '{`SLV0_HIGH, `SLV1_HIGH};

  logic [15:0] adr_hi;
  slave_hit_t  in_window;

  assign adr_hi = wbm_adr_i[`WB_ADR_W-1 -: 16];

  // raw window compare.
  always_comb begin
    for (int i = 0; i < `WB_NUM_SLAVES; i++) begin
      in_window[i] = (adr_hi >= SLV_BASE[i][`WB_ADR_W-1 -: 16]) &&
                     (adr_hi <= SLV_HIGH[i]);
    end
  end

  // priority pick.
  // scanning downwards lets the lowest numbered window win.
  always_comb begin
    hit_o        = '0;
    slave_id_o   = SLV_FAST;
    no_hit_o     = 1'b1;
    offset_adr_o = wbm_adr_i; // unchanged on a miss.
    for (int i = `WB_NUM_SLAVES - 1; i >= 0; i--) begin
      if (in_window[i]) begin
        hit_o        = '0;
        hit_o[i]     = 1'b1;
        slave_id_o   = slave_id_e'(i[0]);
        no_hit_o     = 1'b0;
        offset_adr_o = wbm_adr_i - SLV_BASE[i]; // slave-local address.
      end
    end
  end

endmodule

//--- design/wbs_arbiter.sv
`include "wb_fabric_consts.svh"

module wbs_arbiter
  import wb_bus_pkg::*, wb_map_pkg::*;
(
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // master side
  input  logic                 wbm_cyc_i,
  input  logic                 wbm_stb_i,
  input  logic                 wbm_we_i,
  input  logic [`WB_SEL_W-1:0] wbm_sel_i,
  input  logic [`WB_DAT_W-1:0] wbm_dat_i,
  output logic [`WB_DAT_W-1:0] wbm_dat_o,
  output logic                 wbm_ack_o,
  output logic                 wbm_err_o,
  // decoder
  input  slave_hit_t           hit_i,
  input  slave_id_e            slave_id_i,
  input  logic                 no_hit_i,
  input  logic [`WB_ADR_W-1:0] offset_adr_i,
  // watchdog
  input  logic                 timeout_i,
  output logic                 count_en_o,
  // slave side
  output slave_hit_t           wbs_cyc_o,
  output slave_hit_t           wbs_stb_o,
  output logic                 wbs_we_o,
  output logic [`WB_SEL_W-1:0] wbs_sel_o,
  output logic [`WB_ADR_W-1:0] wbs_adr_o,
  output logic [`WB_DAT_W-1:0] wbs_dat_o,
  input  slave_hit_t           wbs_ack_i,
  input  logic [`WB_DAT_W-1:0] wbs0_dat_i,
  input  logic [`WB_DAT_W-1:0] wbs1_dat_i
);

  arb_state_e state;
  slave_hit_t active_hit; // target of the transfer in flight.
  slave_id_e  active_id;
  logic       req;
  logic       ack_hit;

  // the cycle carrying ack or err closes the previous transfer.
  assign req = (state == ARB_IDLE) && wbm_cyc_i && wbm_stb_i && !wbm_ack_o && !wbm_err_o;
  assign ack_hit = (state == ARB_WAIT) && |(wbs_ack_i & active_hit);

  assign count_en_o = (state == ARB_WAIT);

  // shared slave signals pass straight through.
  assign wbs_we_o  = wbm_we_i;
  assign wbs_sel_o = wbm_sel_i;
  assign wbs_dat_o = wbm_dat_i;

  // ########################################
  // transaction FSM
  // ########################################

  always_ff @(posedge wb_clk_i) begin
    wbs_cyc_o <= '0; // strobes are single-cycle pulses.
    wbs_stb_o <= '0;
    wbm_ack_o <= 1'b0;
    wbm_err_o <= 1'b0;
    if (wb_rst_i) begin
      state      <= ARB_IDLE;
      active_hit <= '0;
      active_id  <= SLV_FAST;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (req) begin
            active_hit <= no_hit_i ? '0 : hit_i; // a miss strobes nobody.
            active_id  <= slave_id_i;
            wbs_cyc_o  <= no_hit_i ? '0 : hit_i;
            wbs_stb_o  <= no_hit_i ? '0 : hit_i;
            state      <= ARB_WAIT;
          end
        end
        ARB_WAIT: begin
          if (ack_hit) begin
            wbm_ack_o <= 1'b1;
            state     <= ARB_IDLE;
          end else if (timeout_i) begin
            wbm_err_o <= 1'b1;
            state     <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // payload registers.
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      wbs_adr_o <= offset_adr_i;
    end
    if (ack_hit) begin
      wbm_dat_o <= (active_id == SLV_SLOW) ? wbs1_dat_i : wbs0_dat_i;
    end
  end

  // ########################################
  // checks
  // ########################################

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_ack_o && wbm_err_o)
  );

  a_stb_onehot: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(wbs_stb_o)
  );

  // no new strobe while a transfer is pending.
  a_no_stb_in_wait: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (state == ARB_WAIT) |=> (wbs_stb_o == '0)
  );

endmodule

//--- design/wbs_reg_bank.sv
`include "wb_fabric_consts.svh"

module wbs_reg_bank
  import wb_bus_pkg::*;
#(
  parameter int WAIT_CYCLES = 0
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_we_i,
  input  logic [`WB_SEL_W-1:0] wbs_sel_i,
  input  logic [`WB_ADR_W-1:0] wbs_adr_i,
  input  logic [`WB_DAT_W-1:0] wbs_dat_i,
  output logic [`WB_DAT_W-1:0] wbs_dat_o,
  output logic                 wbs_ack_o
);

  localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

  logic [`WB_DAT_W-1:0] regs [16];
  logic [3:0]           idx;
  logic                 access;
  bank_state_e          state;
  logic [CNT_W-1:0]     delay_cnt;

  assign idx    = wbs_adr_i[4:1]; // word index, upper offsets alias.
  assign access = wbs_cyc_i && wbs_stb_i && (state == BANK_IDLE);

  // register file, byte lanes follow sel.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (access && wbs_we_i) begin
      for (int b = 0; b < `WB_SEL_W; b++) begin
        if (wbs_sel_i[b]) begin
          regs[idx][8*b +: 8] <= wbs_dat_i[8*b +: 8];
        end
      end
    end
  end

  // read data taken at the strobe, held through ack.
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      wbs_dat_o <= regs[idx];
    end
  end

  // ack delay.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= BANK_IDLE;
      delay_cnt <= '0;
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= 1'b0;
      case (state)
        BANK_IDLE: begin
          if (access && (WAIT_CYCLES == 0)) begin
            wbs_ack_o <= 1'b1; // zero wait.
          end else if (access) begin
            state     <= BANK_DELAY;
            delay_cnt <= CNT_W'((WAIT_CYCLES > 0) ? WAIT_CYCLES - 1 : 0);
          end
        end
        BANK_DELAY: begin
          if (delay_cnt == '0) begin
            wbs_ack_o <= 1'b1;
            state     <= BANK_IDLE;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        default: state <= BANK_IDLE;
      endcase
    end
  end

endmodule

//--- tb/tb_wb_fabric.sv
`include "wb_fabric_consts.svh"

module tb_wb_fabric;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          FAST_LAT     = 2;
  localparam int          SLOW_LAT     = 2 + `SLV1_WAIT;
  localparam int          ERR_LAT      = `WB_TIMEOUT + 2;
  localparam logic [31:0] UNMAPPED_ADR = 32'h0005_0000;

  logic                 wb_clk_i = 1'b0;
  logic                 wb_rst_i;
  logic                 wbm_cyc_i;
  logic                 wbm_stb_i;
  logic                 wbm_we_i;
  logic [`WB_SEL_W-1:0] wbm_sel_i;
  logic [`WB_ADR_W-1:0] wbm_adr_i;
  logic [`WB_DAT_W-1:0] wbm_dat_i;
  logic [`WB_DAT_W-1:0] wbm_dat_o;
  logic                 wbm_ack_o;
  logic                 wbm_err_o;

  logic [15:0] model [2][16];     // expected bank contents.
  logic [31:0] lfsr_q = 32'haea3_22bc;
  logic        last_ack;
  logic        last_err;
  logic [15:0] last_rdat;
  int          last_lat;          // edges after the sampling edge.

  wb_fabric_top u_wb_fabric_top (
    .wb_clk_i  (wb_clk_i),  .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i), .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),  .wbm_sel_i (wbm_sel_i),
    .wbm_adr_i (wbm_adr_i), .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  // ########################################
  // helpers
  // ########################################

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [15:0] w);
    w = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[14:0], lfsr_q[0]}; // one step per bit.
    end
  endtask

  function automatic logic [31:0] slave_base(input int slv);
    return (slv == 1) ? `SLV1_BASE : `SLV0_BASE;
  endfunction

  function automatic logic [31:0] slave_adr(input int slv, input int idx);
    return slave_base(slv) + 32'(idx * 2);
  endfunction

  function automatic int slave_lat(input int slv);
    return (slv == 1) ? SLOW_LAT : FAST_LAT;
  endfunction

  // byte lanes follow sel.
  task automatic model_write(input int slv, input int idx, input logic [1:0] sel,
                             input logic [15:0] dat);
    if (sel[0]) begin
      model[slv][idx][7:0] = dat[7:0];
    end
    if (sel[1]) begin
      model[slv][idx][15:8] = dat[15:8];
    end
  endtask

  task automatic expect_equal(input string name, input string item,
                              input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", name, item, exp, act);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic expect_response(input string name, input logic exp_err, input int exp_lat);
    expect_equal(name, "ack", !exp_err, last_ack);
    expect_equal(name, "err", exp_err, last_err);
    expect_equal(name, "latency", exp_lat, last_lat);
  endtask

  // one master transfer, entered 1 ns after a rising edge.
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat);
    int lat;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    wbm_we_i  = we;
    wbm_sel_i = sel;
    wbm_adr_i = adr;
    wbm_dat_i = dat;
    @(posedge wb_clk_i); // request sampled here.
    lat      = 0;
    last_ack = 1'b0;
    last_err = 1'b0;
    while (!last_ack && !last_err) begin
      @(posedge wb_clk_i);
      #1;
      lat++;
      last_ack = wbm_ack_o;
      last_err = wbm_err_o;
      assert (lat <= ERR_LAT + 2) else begin
        $display("ERROR: no ack or err came within %0d edges of the request", lat);
        $display("TEST FAILED");
        $fatal(1, "bus cycle stuck");
      end
    end
    assert (!(wbm_ack_o && wbm_err_o)) else begin
      $display("ERROR: ack and err were high in the same cycle");
      $display("TEST FAILED");
      $fatal(1, "ack with err");
    end
    last_rdat = wbm_dat_o;
    last_lat  = lat;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    @(posedge wb_clk_i); // one idle cycle between requests.
    #1;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [1:0] sel,
                          input logic [15:0] dat);
    bus_cycle(1'b1, adr, sel, dat);
  endtask

  task automatic wb_read(input logic [31:0] adr);
    bus_cycle(1'b0, adr, 2'b11, 16'h0000);
  endtask

  // ########################################
  // directed tests
  // ########################################

  task automatic test_readback(input string name, input int slv);
    logic [15:0] dat;
    for (int i = 0; i < 8; i++) begin
      rand_word(dat);
      wb_write(slave_adr(slv, 2 * i), 2'b11, dat);
      expect_response(name, 1'b0, slave_lat(slv));
      model_write(slv, 2 * i, 2'b11, dat);
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(slave_adr(slv, 2 * i));
      expect_response(name, 1'b0, slave_lat(slv));
      expect_equal(name, "read data", model[slv][2 * i], last_rdat);
    end
  endtask

  task automatic test_byte_select();
    logic [15:0] dat;
    for (int slv = 0; slv < 2; slv++) begin
      wb_write(slave_adr(slv, 3), 2'b11, 16'ha5c3); // known background.
      model_write(slv, 3, 2'b11, 16'ha5c3);
      for (int s = 1; s <= 2; s++) begin
        rand_word(dat);
        wb_write(slave_adr(slv, 3), 2'(s), dat);
        model_write(slv, 3, 2'(s), dat);
        wb_read(slave_adr(slv, 3));
        expect_response("byte select", 1'b0, slave_lat(slv));
        expect_equal("byte select", "merged word", model[slv][3], last_rdat);
      end
    end
  endtask

  task automatic test_isolation();
    logic [15:0] dat;
    logic [31:0] top_adr;
    logic [31:0] off;
    int          idx;
    for (int slv = 0; slv < 2; slv++) begin
      rand_word(dat);
      wb_write(slave_adr(slv, 5), 2'b11, dat);
      model_write(slv, 5, 2'b11, dat);
    end
    for (int slv = 0; slv < 2; slv++) begin
      wb_read(slave_adr(slv, 5));
      expect_response("isolation", 1'b0, slave_lat(slv));
      expect_equal("isolation", "same offset", model[slv][5], last_rdat);
    end
    // top word of each window.
    for (int slv = 0; slv < 2; slv++) begin
      top_adr = {((slv == 1) ? `SLV1_HIGH : `SLV0_HIGH), 16'hfffe};
      off     = top_adr - slave_base(slv);
      idx     = int'(off[4:1]);
      rand_word(dat);
      wb_write(top_adr, 2'b11, dat);
      expect_response("window top", 1'b0, slave_lat(slv));
      model_write(slv, idx, 2'b11, dat);
      wb_read(slave_adr(slv, idx));
      expect_response("window top", 1'b0, slave_lat(slv));
      expect_equal("window top", "aliased word", model[slv][idx], last_rdat);
    end
  endtask

  task automatic test_unmapped();
    wb_read(UNMAPPED_ADR);
    expect_response("unmapped read", 1'b1, ERR_LAT);
    wb_write(UNMAPPED_ADR, 2'b11, 16'hdead);
    expect_response("unmapped write", 1'b1, ERR_LAT);
    for (int slv = 0; slv < 2; slv++) begin
      for (int idx = 0; idx < 16; idx++) begin
        wb_read(slave_adr(slv, idx));
        expect_equal("unmapped", "bank word", model[slv][idx], last_rdat);
      end
    end
  endtask

  // ########################################
  // main sequence and watchdog
  // ########################################

  initial begin
    wb_rst_i  = 1'b1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    wbm_sel_i = '0;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    for (int slv = 0; slv < 2; slv++) begin
      for (int idx = 0; idx < 16; idx++) begin
        model[slv][idx] = '0; // banks come out of reset cleared.
      end
    end
    repeat (16) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    test_readback("fast readback", 0);
    test_readback("slow readback", 1);
    test_byte_select();
    test_isolation();
    test_unmapped();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(200 * (`WB_TIMEOUT + 4) * 10);
    $display("ERROR: simulation hung, watchdog expired");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- wb_fabric.f
+incdir+design
design/wb_bus_pkg.sv
design/wb_map_pkg.sv
design/wbs_addr_decode.sv
design/wb_bus_watchdog.sv
design/wbs_arbiter.sv
design/wbs_reg_bank.sv
design/wb_fabric_top.sv
tb/tb_wb_fabric.sv
